/* Bender.yml */
package:
  name: ppu_spr

sources:
  - hw/spr_pkg.sv
  - hw/spr_oam.sv
  - hw/spr_eval.sv
  - hw/spr_fetch.sv
  - hw/spr_render.sv
  - hw/ppu_spr.sv
  - target: test
    files:
      - tb/tb_ppu_spr.sv

/* hw/ppu_spr.sv */
//////////////////////////////
// sprite unit top, 8x8 sprites only
// enable, clip and table select are held levels
//////////////////////////////
module ppu_spr
(
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          en,
  input  logic                          ls_clip,
  input  logic                          pt_sel,
  input  logic [7:0]                    oam_a,
  input  logic [7:0]                    oam_d,
  input  logic                          oam_wr,
  input  logic [spr_pkg::COORD_W-1:0]   nes_x,
  input  logic [spr_pkg::COORD_W-1:0]   nes_y,
  input  logic [spr_pkg::COORD_W-1:0]   nes_y_next,
  input  logic                          pix_pulse,
  input  logic [7:0]                    vram_d,
  output logic [7:0]                    oam_q,
  output logic                          overflow,
  output logic [3:0]                    palette_idx,
  output logic                          primary,
  output logic                          prio,
  output logic [spr_pkg::VRAM_A_W-1:0]  vram_a,
  output logic                          vram_req
);

  spr_pkg::oam_entry_u entry;
  logic [5:0]          entry_idx;
  logic [3:0]          in_rng_cnt;
  logic [2:0]          stm_rd_idx;
  logic [7:0]          stm_tile;
  logic [7:0]          stm_x;
  logic [1:0]          stm_ps;
  logic                stm_prio;
  logic                stm_hflip;
  logic [2:0]          stm_row;
  logic                stm_primary;
  logic                sbm_wr;
  logic [2:0]          sbm_a;
  logic                sbm_primary;
  logic                sbm_prio;
  logic [1:0]          sbm_ps;
  logic [7:0]          sbm_pd1;
  logic [7:0]          sbm_pd0;
  logic [7:0]          sbm_x;

  spr_oam u_oam
  (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .oam_a     (oam_a),
    .oam_d     (oam_d),
    .oam_wr    (oam_wr),
    .entry_idx (entry_idx),
    .oam_q     (oam_q),
    .entry     (entry)
  );

  spr_eval u_eval
  (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .en          (en),
    .nes_x       (nes_x),
    .nes_y_next  (nes_y_next),
    .pix_pulse   (pix_pulse),
    .entry       (entry),
    .stm_rd_idx  (stm_rd_idx),
    .entry_idx   (entry_idx),
    .in_rng_cnt  (in_rng_cnt),
    .overflow    (overflow),
    .stm_tile    (stm_tile),
    .stm_x       (stm_x),
    .stm_ps      (stm_ps),
    .stm_prio    (stm_prio),
    .stm_hflip   (stm_hflip),
    .stm_row     (stm_row),
    .stm_primary (stm_primary)
  );

  spr_fetch u_fetch
  (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .en          (en),
    .pt_sel      (pt_sel),
    .nes_x       (nes_x),
    .nes_y_next  (nes_y_next),
    .in_rng_cnt  (in_rng_cnt),
    .stm_tile    (stm_tile),
    .stm_x       (stm_x),
    .stm_ps      (stm_ps),
    .stm_prio    (stm_prio),
    .stm_hflip   (stm_hflip),
    .stm_row     (stm_row),
    .stm_primary (stm_primary),
    .vram_d      (vram_d),
    .stm_rd_idx  (stm_rd_idx),
    .vram_a      (vram_a),
    .vram_req    (vram_req),
    .sbm_wr      (sbm_wr),
    .sbm_a       (sbm_a),
    .sbm_primary (sbm_primary),
    .sbm_prio    (sbm_prio),
    .sbm_ps      (sbm_ps),
    .sbm_pd1     (sbm_pd1),
    .sbm_pd0     (sbm_pd0),
    .sbm_x       (sbm_x)
  );

  spr_render u_render
  (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .en          (en),
    .ls_clip     (ls_clip),
    .nes_x       (nes_x),
    .nes_y       (nes_y),
    .pix_pulse   (pix_pulse),
    .sbm_wr      (sbm_wr),
    .sbm_a       (sbm_a),
    .sbm_primary (sbm_primary),
    .sbm_prio    (sbm_prio),
    .sbm_ps      (sbm_ps),
    .sbm_pd1     (sbm_pd1),
    .sbm_pd0     (sbm_pd0),
    .sbm_x       (sbm_x),
    .palette_idx (palette_idx),
    .primary     (primary),
    .prio        (prio)
  );

endmodule

/* hw/spr_eval.sv */
//////////////////////////////
// in-range search for the line in nes_y_next
// one object per 4 dots over dots 0..255, first 8 hits kept
// overflow is sticky for the frame and also sets at exactly 8
//////////////////////////////
module spr_eval
(
  input  logic                                     clk_in,
  input  logic                                     rst_in,
  input  logic                                     en,
  input  logic [spr_pkg::COORD_W-1:0]              nes_x,
  input  logic [spr_pkg::COORD_W-1:0]              nes_y_next,
  input  logic                                     pix_pulse,
  input  spr_pkg::oam_entry_u                      entry,
  input  logic [2:0]                               stm_rd_idx,
  output logic [$clog2(spr_pkg::OAM_ENTRIES)-1:0]  entry_idx,
  output logic [3:0]                               in_rng_cnt,
  output logic                                     overflow,
  output logic [7:0]                               stm_tile,
  output logic [7:0]                               stm_x,
  output logic [1:0]                               stm_ps,
  output logic                                     stm_prio,
  output logic                                     stm_hflip,
  output logic [2:0]                               stm_row,
  output logic                                     stm_primary
);

  //////////////////////////////
  // sprite temporary memory, one array per field
  //////////////////////////////
  logic [7:0] stm_tile_m    [spr_pkg::SPR_PER_LINE];
  logic [7:0] stm_x_m       [spr_pkg::SPR_PER_LINE];
  logic [1:0] stm_ps_m      [spr_pkg::SPR_PER_LINE];
  logic       stm_prio_m    [spr_pkg::SPR_PER_LINE];
  logic       stm_hflip_m   [spr_pkg::SPR_PER_LINE];
  logic [2:0] stm_row_m     [spr_pkg::SPR_PER_LINE];
  logic       stm_primary_m [spr_pkg::SPR_PER_LINE];

  logic [spr_pkg::COORD_W-1:0] rng_diff;  // next line minus top row
  logic                        in_rng;
  logic                        stm_wr;
  logic [2:0]                  row;

  assign entry_idx = nes_x[7:2];

  // oam y is the top row minus one
  assign rng_diff = nes_y_next - ({2'b00, entry.f.y} + 10'd1);
  assign in_rng   = (rng_diff < spr_pkg::SPR_ROWS);  // negative wraps to a large value
  assign row      = rng_diff[2:0] ^ {3{entry.f.attr[spr_pkg::ATTR_VFLIP]}};

  assign stm_wr = en && pix_pulse && (nes_y_next < spr_pkg::VISIBLE_LINES)
                  && (nes_x < spr_pkg::VISIBLE_DOTS) && (nes_x[1:0] == 2'b00)
                  && in_rng && (in_rng_cnt < spr_pkg::SPR_PER_LINE);

  always_ff @(posedge clk_in)
  begin
    if (stm_wr)
    begin
      stm_tile_m[in_rng_cnt[2:0]]    <= entry.f.tile;
      stm_x_m[in_rng_cnt[2:0]]       <= entry.f.x;
      stm_ps_m[in_rng_cnt[2:0]]      <= entry.f.attr[spr_pkg::ATTR_PS_LSB +: 2];
      stm_prio_m[in_rng_cnt[2:0]]    <= entry.f.attr[spr_pkg::ATTR_PRIO];
      stm_hflip_m[in_rng_cnt[2:0]]   <= entry.f.attr[spr_pkg::ATTR_HFLIP];
      stm_row_m[in_rng_cnt[2:0]]     <= row;
      stm_primary_m[in_rng_cnt[2:0]] <= (entry_idx == '0);  // object 0
    end
  end

  //////////////////////////////
  // count and overflow
  //////////////////////////////
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      in_rng_cnt <= 4'd0;
      overflow   <= 1'b0;
    end
    else
    begin
      if (pix_pulse && (nes_x == spr_pkg::FETCH_END_DOT))
        in_rng_cnt <= 4'd0;             // fetch done, ready for the next line
      else if (stm_wr)
        in_rng_cnt <= in_rng_cnt + 4'd1;

      if ((nes_y_next == '0) && (nes_x == '0))
        overflow <= 1'b0;               // new frame
      else if (in_rng_cnt == spr_pkg::SPR_PER_LINE)
        overflow <= 1'b1;
    end
  end

  // read port for the pattern fetch
  assign stm_tile    = stm_tile_m[stm_rd_idx];
  assign stm_x       = stm_x_m[stm_rd_idx];
  assign stm_ps      = stm_ps_m[stm_rd_idx];
  assign stm_prio    = stm_prio_m[stm_rd_idx];
  assign stm_hflip   = stm_hflip_m[stm_rd_idx];
  assign stm_row     = stm_row_m[stm_rd_idx];
  assign stm_primary = stm_primary_m[stm_rd_idx];

  a_cnt_max : assert property (
    @(posedge clk_in) disable iff (rst_in)
    in_rng_cnt <= 4'(spr_pkg::SPR_PER_LINE)
  );

endmodule

/* hw/spr_fetch.sv */
//////////////////////////////
// pattern fetch over dots 256..319, 8 dots per slot
// vram_d must be valid in the same clock as vram_a
//////////////////////////////
module spr_fetch
(
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          en,
  input  logic                          pt_sel,      // pattern table select
  input  logic [spr_pkg::COORD_W-1:0]   nes_x,
  input  logic [spr_pkg::COORD_W-1:0]   nes_y_next,
  input  logic [3:0]                    in_rng_cnt,
  input  logic [7:0]                    stm_tile,
  input  logic [7:0]                    stm_x,
  input  logic [1:0]                    stm_ps,
  input  logic                          stm_prio,
  input  logic                          stm_hflip,
  input  logic [2:0]                    stm_row,
  input  logic                          stm_primary,
  input  logic [7:0]                    vram_d,
  output logic [2:0]                    stm_rd_idx,
  output logic [spr_pkg::VRAM_A_W-1:0]  vram_a,
  output logic                          vram_req,
  output logic                          sbm_wr,
  output logic [2:0]                    sbm_a,
  output logic                          sbm_primary,
  output logic                          sbm_prio,
  output logic [1:0]                    sbm_ps,
  output logic [7:0]                    sbm_pd1,
  output logic [7:0]                    sbm_pd0,
  output logic [7:0]                    sbm_x
);

  logic [1:0] phase;     // 0 low plane, 1 high plane, 2 commit
  logic       fetch_act;
  logic       slot_vld;  // slot holds a found sprite
  logic [7:0] pat;
  logic [7:0] pd0_q;
  logic [7:0] pd1_q;

  function automatic logic [7:0] bit_rev(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[i] = b[7-i];
    return r;
  endfunction

  assign stm_rd_idx = nes_x[5:3];
  assign phase      = nes_x[2:1];

  assign fetch_act = en && (nes_y_next < spr_pkg::VISIBLE_LINES)
                     && (nes_x >= spr_pkg::VISIBLE_DOTS) && (nes_x < spr_pkg::FETCH_END_DOT);
  assign slot_vld  = ({1'b0, stm_rd_idx} < in_rng_cnt);

  // table, tile, plane, row
  assign vram_a   = {pt_sel, stm_tile, nes_x[1], stm_row};
  assign vram_req = fetch_act && slot_vld && (phase <= 2'd1);

  // shifters output bit 0 first, so the unflipped byte goes in reversed
  assign pat = stm_hflip ? vram_d : bit_rev(vram_d);

  //////////////////////////////
  // pattern latches
  //////////////////////////////
  always_ff @(posedge clk_in)
  begin
    if (fetch_act && slot_vld)
    begin
      if (phase == 2'd0)
        pd0_q <= pat;
      else if (phase == 2'd1)
        pd1_q <= pat;
    end
  end

  // empty slots are written all zero for the whole slot
  assign sbm_wr      = fetch_act && (!slot_vld || (phase == 2'd2));
  assign sbm_a       = stm_rd_idx;
  assign sbm_primary = slot_vld & stm_primary;
  assign sbm_prio    = slot_vld & stm_prio;
  assign sbm_ps      = slot_vld ? stm_ps : 2'b00;
  assign sbm_pd1     = slot_vld ? pd1_q  : 8'h00;
  assign sbm_pd0     = slot_vld ? pd0_q  : 8'h00;
  assign sbm_x       = slot_vld ? stm_x  : 8'h00;

  a_req_window : assert property (
    @(posedge clk_in) disable iff (rst_in)
    vram_req |-> ((nes_x >= spr_pkg::VISIBLE_DOTS) && (nes_x < spr_pkg::FETCH_END_DOT))
  );

endmodule

/* hw/spr_oam.sv */
//////////////////////////////
// object attribute memory, 64 entries of 4 bytes
// cpu readback and entry read are combinational
//////////////////////////////
module spr_oam
(
  input  logic                                     clk_in,
  input  logic                                     rst_in,
  input  logic [$clog2(spr_pkg::OAM_BYTES)-1:0]    oam_a,     // cpu byte address
  input  logic [7:0]                               oam_d,
  input  logic                                     oam_wr,
  input  logic [$clog2(spr_pkg::OAM_ENTRIES)-1:0]  entry_idx, // object index from the search
  output logic [7:0]                               oam_q,
  output spr_pkg::oam_entry_u                      entry
);

  spr_pkg::oam_entry_u mem [spr_pkg::OAM_ENTRIES];

  logic [$clog2(spr_pkg::OAM_ENTRIES)-1:0] cpu_idx;
  logic [1:0]                              cpu_lane;

  assign cpu_idx  = oam_a[7:2];
  assign cpu_lane = oam_a[1:0];  // byte within the entry

  //////////////////////////////
  // byte-lane write port
  //////////////////////////////
  always_ff @(posedge clk_in)
  begin
    if (oam_wr)
    begin
      mem[cpu_idx].bytes[cpu_lane] <= oam_d;
    end
  end

  assign oam_q = mem[cpu_idx].bytes[cpu_lane];
  assign entry = mem[entry_idx];  // whole entry for the in-range search

endmodule

/* hw/spr_pkg.sv */
//////////////////////////////
// constants and the oam entry type for the sprite unit
// only 8x8 sprites are supported, there is no 8x16 mode
// oam byte 0 holds y, byte 3 holds x
//////////////////////////////
package spr_pkg;

  //////////////////////////////
  // object memory and per-line limits
  //////////////////////////////
  localparam int OAM_ENTRIES  = 64;   // objects in oam
  localparam int OAM_BYTES    = 256;  // cpu-visible byte space
  localparam int SPR_PER_LINE = 8;
  localparam int SPR_ROWS     = 8;    // rows per sprite

  //////////////////////////////
  // scan timing
  //////////////////////////////
  localparam int COORD_W       = 10;
  localparam int VISIBLE_LINES = 240;
  localparam int VISIBLE_DOTS  = 256;  // fetch begins here
  localparam int FETCH_END_DOT = 320;  // fetch ends, in-range count clears
  localparam int CLIP_DOTS     = 8;

  // pattern table address width
  localparam int VRAM_A_W = 13;

  // bit positions inside the attribute byte
  localparam int ATTR_PS_LSB = 0;  // two palette bits from here
  localparam int ATTR_PRIO   = 5;  // 1 puts the sprite behind the playfield
  localparam int ATTR_HFLIP  = 6;
  localparam int ATTR_VFLIP  = 7;

  // one oam entry, written by the cpu as bytes and read by the search as fields
  typedef union packed
  {
    logic [3:0][7:0] bytes;
    struct packed
    {
      logic [7:0] x;     // byte 3, left column
      logic [7:0] attr;  // byte 2
      logic [7:0] tile;  // byte 1
      logic [7:0] y;     // byte 0, top row minus one
    } f;
  } oam_entry_u;

endpackage

/* hw/spr_render.sv */
//////////////////////////////
// sprite buffer and eight pixel shifters
// lowest slot with a nonzero pixel wins
// a shifter reloads whenever nes_x[7:0] matches its x start
//////////////////////////////
module spr_render
(
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         en,
  input  logic                         ls_clip,   // blank the left 8 dots
  input  logic [spr_pkg::COORD_W-1:0]  nes_x,
  input  logic [spr_pkg::COORD_W-1:0]  nes_y,
  input  logic                         pix_pulse,
  input  logic                         sbm_wr,
  input  logic [2:0]                   sbm_a,
  input  logic                         sbm_primary,
  input  logic                         sbm_prio,
  input  logic [1:0]                   sbm_ps,
  input  logic [7:0]                   sbm_pd1,
  input  logic [7:0]                   sbm_pd0,
  input  logic [7:0]                   sbm_x,
  output logic [3:0]                   palette_idx,
  output logic                         primary,
  output logic                         prio
);

  //////////////////////////////
  // sprite buffer memory
  //////////////////////////////
  logic       sbm_primary_m [spr_pkg::SPR_PER_LINE];
  logic       sbm_prio_m    [spr_pkg::SPR_PER_LINE];
  logic [1:0] sbm_ps_m      [spr_pkg::SPR_PER_LINE];
  logic [7:0] sbm_pd1_m     [spr_pkg::SPR_PER_LINE];
  logic [7:0] sbm_pd0_m     [spr_pkg::SPR_PER_LINE];
  logic [7:0] sbm_x_m       [spr_pkg::SPR_PER_LINE];

  logic [7:0] sh1_q [spr_pkg::SPR_PER_LINE];  // high plane shifters
  logic [7:0] sh0_q [spr_pkg::SPR_PER_LINE];  // low plane shifters
  logic       clip_now;

  always_ff @(posedge clk_in)
  begin
    if (sbm_wr)
    begin
      sbm_primary_m[sbm_a] <= sbm_primary;
      sbm_prio_m[sbm_a]    <= sbm_prio;
      sbm_ps_m[sbm_a]      <= sbm_ps;
      sbm_pd1_m[sbm_a]     <= sbm_pd1;
      sbm_pd0_m[sbm_a]     <= sbm_pd0;
      sbm_x_m[sbm_a]       <= sbm_x;
    end
  end

  //////////////////////////////
  // shifters
  //////////////////////////////
  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < spr_pkg::SPR_PER_LINE; i++)
      begin
        sh1_q[i] <= 8'h00;
        sh0_q[i] <= 8'h00;
      end
    end
    else if (en && (nes_y < spr_pkg::VISIBLE_LINES))
    begin
      for (int i = 0; i < spr_pkg::SPR_PER_LINE; i++)
      begin
        if (pix_pulse)
        begin
          sh1_q[i] <= {1'b0, sh1_q[i][7:1]};
          sh0_q[i] <= {1'b0, sh0_q[i][7:1]};
        end
        else if (nes_x[7:0] == sbm_x_m[i])
        begin
          sh1_q[i] <= sbm_pd1_m[i];  // start of this sprite's span
          sh0_q[i] <= sbm_pd0_m[i];
        end
      end
    end
  end

  assign clip_now = ls_clip && (nes_x < spr_pkg::CLIP_DOTS);

  //////////////////////////////
  // priority select
  //////////////////////////////
  always_comb
  begin
    palette_idx = 4'h0;
    primary     = 1'b0;
    prio        = 1'b0;
    // walk down so the lowest nonzero slot is assigned last
    for (int i = spr_pkg::SPR_PER_LINE - 1; i >= 0; i--)
    begin
      if (sh1_q[i][0] | sh0_q[i][0])
      begin
        palette_idx = {sbm_ps_m[i], sh1_q[i][0], sh0_q[i][0]};
        primary     = sbm_primary_m[i];
        prio        = sbm_prio_m[i];
      end
    end
    if (clip_now)
    begin
      palette_idx = 4'h0;
      primary     = 1'b0;
      prio        = 1'b0;
    end
  end

  a_clip_blank : assert property (
    @(posedge clk_in) disable iff (rst_in)
    clip_now |-> ((palette_idx == 4'h0) && !primary && !prio)
  );

endmodule

/* tb.f */
hw/spr_pkg.sv
hw/spr_oam.sv
hw/spr_eval.sv
hw/spr_fetch.sv
hw/spr_render.sv
hw/ppu_spr.sv
tb/tb_ppu_spr.sv

/* tb/tb_ppu_spr.sv */
//////////////////////////////
// random testbench for the sprite unit, 4 clocks per dot and 341 dots per line
// the pattern memory is a hash of vram_a and answers in the same clock
// sprite x start 72..90 is avoided, those late loads spill into the next line
//////////////////////////////
module tb_ppu_spr;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DOT_CLKS      = 4;
  localparam int LINE_DOTS     = 341;
  localparam int NUM_LINES     = 31;   // all scanlines run by all tests
  localparam int OAM_PASSES    = 16;   // full oam writes and reads
  localparam int OAM_PASS_CLKS = 258;
  localparam int CYCLE_LIMIT   =
    (NUM_LINES * LINE_DOTS * DOT_CLKS + OAM_PASSES * OAM_PASS_CLKS) * 6 / 5;

  logic                                 clk_in;
  logic                                 rst_in;
  logic                                 en;
  logic                                 ls_clip;
  logic                                 pt_sel;
  logic [7:0]                           oam_a;
  logic [7:0]                           oam_d;
  logic                                 oam_wr;
  logic [spr_pkg::COORD_W-1:0]          nes_x;
  logic [spr_pkg::COORD_W-1:0]          nes_y;
  logic [spr_pkg::COORD_W-1:0]          nes_y_next;
  logic                                 pix_pulse;
  logic [7:0]                           vram_d;
  logic [7:0]                           oam_q;
  logic                                 overflow;
  logic [3:0]                           palette_idx;
  logic                                 primary;
  logic                                 prio;
  logic [spr_pkg::VRAM_A_W-1:0]         vram_a;
  logic                                 vram_req;

  //////////////////////////////
  // model state
  //////////////////////////////
  logic [31:0] rng;
  logic [7:0]  oam_img [256];   // what oam should hold
  int          found_obj [8];   // first eight in-range objects, oam order
  int          found_n;
  int          hit_total;       // all in-range objects, for overflow
  logic        exp_ovf;
  int          checks;
  int          errors;
  int          tests_failed;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // pattern byte as a hash of the full 13-bit address
  function automatic logic [7:0] pat_byte(input logic [12:0] a);
    logic [31:0] h;
    h = xorshift({19'h0, a} ^ 32'h9e37_79b9);
    h = xorshift(h ^ {a, 19'h0});
    return h[7:0];
  endfunction

  function automatic logic [7:0] safe_x(input logic [7:0] x);
    if ((x >= 8'd72) && (x <= 8'd90))
      return x + 8'd24;
    return x;
  endfunction

  assign vram_d = pat_byte(vram_a);  // combinational pattern memory

  ppu_spr dut
  (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .en          (en),
    .ls_clip     (ls_clip),
    .pt_sel      (pt_sel),
    .oam_a       (oam_a),
    .oam_d       (oam_d),
    .oam_wr      (oam_wr),
    .nes_x       (nes_x),
    .nes_y       (nes_y),
    .nes_y_next  (nes_y_next),
    .pix_pulse   (pix_pulse),
    .vram_d      (vram_d),
    .oam_q       (oam_q),
    .overflow    (overflow),
    .palette_idx (palette_idx),
    .primary     (primary),
    .prio        (prio),
    .vram_a      (vram_a),
    .vram_req    (vram_req)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk_in);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clocks", CYCLE_LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report(input string name, input int c0, input int e0);
    if (errors != e0)
      tests_failed++;
    $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  //////////////////////////////
  // oam images
  //////////////////////////////
  task automatic set_entry(input int i, input logic [7:0] y, input logic [7:0] tile,
                           input logic [7:0] attr, input logic [7:0] x);
    oam_img[4*i]   = y;
    oam_img[4*i+1] = tile;
    oam_img[4*i+2] = attr;
    oam_img[4*i+3] = safe_x(x);
  endtask

  task automatic fill_far();
    logic [31:0] t;
    for (int i = 0; i < 64; i++)
    begin
      t = rand32();
      set_entry(i, 8'hF8, t[7:0], t[15:8], t[23:16]);  // below every tested line
    end
  endtask

  task automatic fill_cluster(input int line, input bit near_left);
    logic [31:0] r;
    logic [31:0] t;
    logic [7:0]  y;
    logic [7:0]  x;
    for (int i = 0; i < 64; i++)
    begin
      r = rand32();
      t = rand32();
      if (r[0])
        y = 8'(line - 9 + int'(r[11:8] % 12));  // rows around the line
      else
        y = r[19:12];
      x = (near_left && r[1]) ? 8'(r[27:24] % 12) : r[31:24];
      set_entry(i, y, t[7:0], t[15:8], x);
    end
  endtask

  task automatic place_hits(input int line, input int n);
    logic [31:0] t;
    for (int k = 0; k < n; k++)
    begin
      t = rand32();
      set_entry((k * 7 + 3) % 64, 8'(line - 1 - int'(t[2:0])), t[15:8], t[23:16], t[31:24]);
    end
  endtask

  task automatic load_oam(input logic tbl);
    for (int a = 0; a < 256; a++)
    begin
      @(posedge clk_in);
      #1;
      pt_sel = tbl;
      oam_a  = 8'(a);
      oam_d  = oam_img[a];
      oam_wr = 1'b1;
    end
    @(posedge clk_in);
    #1;
    oam_wr = 1'b0;
  endtask

  //////////////////////////////
  // sprite model
  //////////////////////////////
  task automatic find_sprites(input int line);
    int diff;
    found_n   = 0;
    hit_total = 0;
    for (int i = 0; i < 64; i++)
    begin
      diff = line - (int'(oam_img[4*i]) + 1);  // oam y is top row minus one
      if ((diff >= 0) && (diff < 8))
      begin
        hit_total++;
        if (found_n < 8)
        begin
          found_obj[found_n] = i;
          found_n++;
        end
      end
    end
  endtask

  task automatic expect_pixel(input int line, input int dot, output logic [3:0] pal,
                              output logic pr, output logic prim);
    int         obj;
    int         col;
    int         diff;
    int         b;
    logic [2:0] row;
    logic [7:0] attr;
    logic [7:0] p0;
    logic [7:0] p1;
    logic       hit;
    pal  = 4'h0;
    pr   = 1'b0;
    prim = 1'b0;
    hit  = 1'b0;
    for (int s = 0; s < found_n; s++)
    begin
      obj  = found_obj[s];
      col  = dot - int'(oam_img[4*obj+3]);
      attr = oam_img[4*obj+2];
      if (!hit && (col >= 0) && (col < 8))
      begin
        diff = line - (int'(oam_img[4*obj]) + 1);
        row  = attr[7] ? 3'(7 - diff) : 3'(diff);
        p0   = pat_byte({pt_sel, oam_img[4*obj+1], 1'b0, row});
        p1   = pat_byte({pt_sel, oam_img[4*obj+1], 1'b1, row});
        b    = attr[6] ? col : 7 - col;  // bit 7 is the leftmost pixel
        if (p0[b] || p1[b])
        begin
          hit  = 1'b1;
          pal  = {attr[1:0], p1[b], p0[b]};
          pr   = attr[5];
          prim = (obj == 0);
        end
      end
    end
    if (ls_clip && (dot < 8))
    begin
      pal  = 4'h0;
      pr   = 1'b0;
      prim = 1'b0;
    end
  endtask

  //////////////////////////////
  // scan timing
  //////////////////////////////
  task automatic park_scan();
    @(posedge clk_in);
    #1;
    nes_x      = 10'd340;
    nes_y      = 10'd261;
    nes_y_next = 10'd261;
    pix_pulse  = 1'b0;
  endtask

  task automatic run_line(input int y, input int y_next, input bit check_pix);
    int         req_in;
    int         req_out;
    int         req_exp;
    logic [3:0] e_pal;
    logic       e_pr;
    logic       e_prim;
    req_in  = 0;
    req_out = 0;
    if (y_next == 0)
      exp_ovf = 1'b0;  // frame start
    find_sprites(y);   // sprites shown on this line
    for (int x = 0; x < LINE_DOTS; x++)
    begin
      for (int c = 0; c < DOT_CLKS; c++)
      begin
        @(posedge clk_in);
        #1;
        nes_x      = 10'(x);
        nes_y      = 10'(y);
        nes_y_next = 10'(y_next);
        pix_pulse  = (c == DOT_CLKS - 1);
      end
      #2;  // last clock of the dot
      if (vram_req && (x >= 256) && (x < 320))
        req_in++;
      else if (vram_req)
        req_out++;
      if (check_pix && (x < 256))
      begin
        expect_pixel(y, x, e_pal, e_pr, e_prim);
        check_val($sformatf("palette_idx line %0d dot %0d", y, x), palette_idx, e_pal);
        check_val($sformatf("priority line %0d dot %0d", y, x), prio, e_pr);
        check_val($sformatf("primary line %0d dot %0d", y, x), primary, e_prim);
      end
    end
    park_scan();
    find_sprites(y_next);
    // two plane fetches per found sprite, each two dots long
    req_exp = (y_next < 240) ? 4 * found_n : 0;
    if ((y_next < 240) && (hit_total >= 8))
      exp_ovf = 1'b1;
    check_val($sformatf("vram_req dots in fetch window, line %0d", y), req_in, req_exp);
    check_val($sformatf("vram_req dots outside window, line %0d", y), req_out, 0);
  endtask

  task automatic line_pair(input int line);
    run_line(line - 1, line, 1'b0);
    run_line(line, line + 1, 1'b1);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic oam_readback();
    int          c0;
    int          e0;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    for (int a = 0; a < 256; a++)
    begin
      r          = rand32();
      oam_img[a] = r[7:0];
    end
    load_oam(1'b0);
    for (int a = 0; a < 256; a++)
    begin
      @(posedge clk_in);
      #1;
      oam_a = 8'(a);
      #2;
      check_val($sformatf("oam_q at address %0d", a), oam_q, oam_img[a]);
    end
    report("oam_readback", c0, e0);
  endtask

  task automatic random_pixels();
    int          c0;
    int          e0;
    int          line;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    for (int k = 0; k < 4; k++)
    begin
      r    = rand32();
      line = 20 + int'(r % 180);
      fill_cluster(line, 1'b0);
      load_oam(r[31]);
      line_pair(line);
    end
    report("random_pixels", c0, e0);
  endtask

  task automatic flip_modes();
    int          c0;
    int          e0;
    int          line;
    int          obj;
    logic [1:0]  flips;
    logic [7:0]  attr;
    logic [31:0] r;
    logic [31:0] t;
    c0 = checks;
    e0 = errors;
    for (int k = 0; k < 4; k++)
    begin
      r     = rand32();
      t     = rand32();
      flips = 2'(k);
      line  = 20 + int'(r % 180);
      obj   = (k < 2) ? 0 : 1 + int'(t[29:24] % 63);  // object 0 sets primary
      attr  = {flips[1], flips[0], t[5], 3'b000, t[1:0]};
      fill_far();
      set_entry(obj, 8'(line - 1 - int'(t[10:8])), t[23:16], attr, r[31:24]);
      load_oam(t[31]);
      line_pair(line);
    end
    report("flip_modes", c0, e0);
  endtask

  task automatic left_clip();
    int          c0;
    int          e0;
    int          line;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    @(posedge clk_in);
    #1;
    ls_clip = 1'b1;
    for (int k = 0; k < 2; k++)
    begin
      r    = rand32();
      line = 20 + int'(r % 180);
      fill_cluster(line, 1'b1);
      load_oam(r[31]);
      line_pair(line);
    end
    @(posedge clk_in);
    #1;
    ls_clip = 1'b0;
    report("left_clip", c0, e0);
  endtask

  task automatic overflow_flag();
    int          c0;
    int          e0;
    int          line;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    run_line(261, 0, 1'b0);
    #2;
    check_val("overflow after frame start", overflow, exp_ovf);
    r    = rand32();
    line = 20 + int'(r % 180);
    fill_far();
    place_hits(line, 10);
    load_oam(r[31]);
    line_pair(line);
    #2;
    check_val("overflow after ten hits", overflow, exp_ovf);
    r    = rand32();
    line = 20 + int'(r % 180);
    fill_far();
    place_hits(line, 5);
    load_oam(r[31]);
    line_pair(line);
    #2;
    check_val("overflow after five hits", overflow, exp_ovf);
    run_line(261, 0, 1'b0);
    #2;
    check_val("overflow after second frame start", overflow, exp_ovf);
    report("overflow_flag", c0, e0);
  endtask

  task automatic fetch_requests();
    int          c0;
    int          e0;
    int          line;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    for (int k = 0; k < 2; k++)
    begin
      r    = rand32();
      line = 20 + int'(r % 180);
      fill_cluster(line, 1'b0);
      load_oam(r[31]);
      line_pair(line);
    end
    run_line(239, 240, 1'b0);  // next line is past the visible area
    report("fetch_requests", c0, e0);
  endtask

  initial
  begin
    $timeformat(-9, 1, " ns", 0);
    rng          = 32'h10e0_9e69;
    exp_ovf      = 1'b0;
    checks       = 0;
    errors       = 0;
    tests_failed = 0;
    rst_in       = 1'b1;
    en           = 1'b1;
    ls_clip      = 1'b0;
    pt_sel       = 1'b0;
    oam_a        = 8'h00;
    oam_d        = 8'h00;
    oam_wr       = 1'b0;
    nes_x        = 10'd340;
    nes_y        = 10'd261;
    nes_y_next   = 10'd261;
    pix_pulse    = 1'b0;
    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    oam_readback();
    random_pixels();
    flip_modes();
    left_clip();
    overflow_flag();
    fetch_requests();

    $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
